//--- Makefile
# Verilator simulation of the TCP frame builder

VERILATOR ?= verilator
TOP       ?= tb_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Simulation passed$$" $(LOG) || { echo "Run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/tcp_frame_pkg.sv
package tcp_frame_pkg;

	// ------------------------------
	// Widths
	localparam int WORD_W     = 32;
	localparam int HALF_W     = 16;
	localparam int MAC_ADDR_W = 48;
	localparam int IP_ADDR_W  = 32;

	// ------------------------------
	// Header constants
	localparam int IP_VERSION      = 4;
	localparam int IP_HEAD_WORDS   = 5;
	localparam int TCP_BASE_WORDS  = 5;
	// 54 header bytes, so payload starts two bytes into word 13
	localparam int BASE_HEAD_WORDS = 13;
	localparam int ETH_HEAD_BYTES  = 14;
	localparam int IP_HEAD_BYTES   = 20;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_HEADER,
		ST_PAYLOAD
	} frame_state_t;

	typedef logic [15:0] word_idx_t;

endpackage

//--- compile.f
common/tcp_frame_pkg.sv
header/header_fields.sv
header/header_checksum.sv
framer/frame_sequencer.sv
framer/payload_aligner.sv
source/tcp_frame_top.sv
dv/tb_clock.sv
dv/tb_checker.sv
dv/tb_props.sv
dv/tb_top.sv

//--- dv/tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
	parameter int OPT_WORDS = 3
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    start,
	input  logic                    busy,
	input  logic [47:0]             mac_dst,
	input  logic [47:0]             mac_src,
	input  logic [15:0]             mac_type,
	input  logic [7:0]              ip_dsf,
	input  logic [15:0]             ip_id,
	input  logic [2:0]              ip_flag,
	input  logic [12:0]             ip_frag_offset,
	input  logic [7:0]              ip_ttl,
	input  logic [7:0]              ip_prot,
	input  logic [31:0]             ip_src,
	input  logic [31:0]             ip_dst,
	input  logic [15:0]             tcp_src_port,
	input  logic [15:0]             tcp_dst_port,
	input  logic [31:0]             tcp_seq_num,
	input  logic [31:0]             tcp_ack_num,
	input  logic [3:0]              tcp_head_len,
	input  logic [5:0]              tcp_flags,
	input  logic [15:0]             tcp_window,
	input  logic [15:0]             tcp_urgent_ptr,
	input  logic [OPT_WORDS*32-1:0] tcp_options,
	input  logic [15:0]             payload_len,
	input  logic [15:0]             payload_sum,
	input  logic                    data_out_rd,
	input  logic [31:0]             data_in,
	input  logic [31:0]             data_out,
	input  logic [1:0]              be_out,
	input  logic                    data_out_rdy,
	input  logic                    sop,
	input  logic                    eop,
	input  logic                    data_in_rd,
	output int                      errors,
	output int                      words_checked,
	output int                      frames_done
);

	logic [7:0] hdr [0:53+4*OPT_WORDS];
	logic [7:0] pay [$];
	int hdr_bytes;
	int total_bytes;
	int last_idx;
	int idx;
	int rd_cnt;
	int plen;
	bit active;
	bit start_ok;

	// End-around carry sum of 16-bit words
	function automatic logic [15:0] add_ones(input logic [15:0] a, input logic [15:0] b);
		logic [16:0] s;
		s = {1'b0, a} + {1'b0, b};
		return s[15:0] + {15'b0, s[16]};
	endfunction

	task automatic put16(input int pos, input logic [15:0] v);
		hdr[pos]     = v[15:8];
		hdr[pos + 1] = v[7:0];
	endtask

	task automatic put32(input int pos, input logic [31:0] v);
		put16(pos, v[31:16]);
		put16(pos + 2, v[15:0]);
	endtask

	// ------------------------------
	// Expected header from the fields at an honored start
	task automatic build_header();
		int k;
		logic [15:0] s;
		logic [15:0] tcp_len;
		k = int'(tcp_head_len) - 5;
		plen = int'(payload_len);
		hdr_bytes = 54 + 4 * k;
		total_bytes = hdr_bytes + plen;
		last_idx = (total_bytes + 3) / 4 - 1;
		tcp_len = 16'(4 * int'(tcp_head_len) + plen);
		put32(0, mac_dst[47:16]);
		put16(4, mac_dst[15:0]);
		put16(6, mac_src[47:32]);
		put32(8, mac_src[31:0]);
		put16(12, mac_type);
		hdr[14] = 8'h45;
		hdr[15] = ip_dsf;
		put16(16, 16'(20 + 4 * int'(tcp_head_len) + plen));
		put16(18, ip_id);
		put16(20, {ip_flag, ip_frag_offset});
		hdr[22] = ip_ttl;
		hdr[23] = ip_prot;
		put16(24, 16'h0);
		put32(26, ip_src);
		put32(30, ip_dst);
		put16(34, tcp_src_port);
		put16(36, tcp_dst_port);
		put32(38, tcp_seq_num);
		put32(42, tcp_ack_num);
		hdr[46] = {tcp_head_len, 4'h0};
		hdr[47] = {2'b00, tcp_flags};
		put16(48, tcp_window);
		put16(50, 16'h0);
		put16(52, tcp_urgent_ptr);
		// Options go out most significant word first
		for (int j = 0; j < k; j++)
			put32(54 + 4 * j, tcp_options[(OPT_WORDS-1-j)*32 +: 32]);

		s = 16'h0;
		for (int p = 14; p < 34; p += 2)
			s = add_ones(s, {hdr[p], hdr[p + 1]});
		put16(24, ~s);

		s = add_ones(ip_src[31:16], ip_src[15:0]);
		s = add_ones(s, ip_dst[31:16]);
		s = add_ones(s, ip_dst[15:0]);
		s = add_ones(s, {8'h0, ip_prot});
		s = add_ones(s, tcp_len);
		for (int p = 34; p < hdr_bytes; p += 2)
			s = add_ones(s, {hdr[p], hdr[p + 1]});
		s = add_ones(s, payload_sum);
		put16(50, ~s);
	endtask

	task automatic compare_word();
		int pos;
		logic [7:0] want;
		logic [7:0] got;
		logic [1:0] want_be;
		for (int b = 0; b < 4; b++) begin
			pos = 4 * idx + b;
			got = data_out[31 - 8 * b -: 8];
			if (pos < total_bytes) begin
				if (pos < hdr_bytes) begin
					want = hdr[pos];
				end else if (pos - hdr_bytes < pay.size()) begin
					want = pay[pos - hdr_bytes];
				end else begin
					want = 8'hxx;
					$display("Payload byte %0d was sent before it was read from the source",
						pos - hdr_bytes);
					errors++;
				end
				if (got !== want && !$isunknown(want)) begin
					$display("Error at %0t ns: word %0d byte %0d is %h, expected %h",
						$time, idx, b, got, want);
					errors++;
				end
			end
		end
		want_be = (idx == last_idx) ? 2'(total_bytes % 4) : 2'b00;
		if (sop !== (idx == 0) || eop !== (idx == last_idx) || be_out !== want_be) begin
			$display("Error at %0t ns: word %0d sop/eop/be %b%b/%0d, expected %b%b/%0d",
				$time, idx, sop, eop, be_out, idx == 0, idx == last_idx, want_be);
			errors++;
		end
		words_checked++;
	endtask

	// ------------------------------
	// Monitor
	always @(posedge clk) begin
		if (!rst_n) begin
			errors = 0;
			words_checked = 0;
			frames_done = 0;
			active = 0;
		end else begin
			start_ok = start && !active;
			if (busy !== active || data_out_rdy !== active) begin
				$display("Error at %0t ns: busy %b, data_out_rdy %b, expected %b",
					$time, busy, data_out_rdy, active);
				errors++;
			end
			if (!active && (sop !== 1'b0 || eop !== 1'b0)) begin
				$display("Error at %0t ns: sop/eop %b%b outside a frame", $time, sop, eop);
				errors++;
			end
			if (data_in_rd) begin
				pay.push_back(data_in[31:24]);
				pay.push_back(data_in[23:16]);
				pay.push_back(data_in[15:8]);
				pay.push_back(data_in[7:0]);
				rd_cnt++;
				if (!active) begin
					$display("The payload source was read while no frame was running");
					errors++;
				end
				if (!(data_out_rdy && data_out_rd)) begin
					$display("The payload source was read on a cycle with no accepted word");
					errors++;
				end
			end
			if (data_out_rdy && data_out_rd) begin
				if (!active) begin
					$display("A word was accepted while no frame was running");
					errors++;
				end else begin
					compare_word();
					if (idx == last_idx) begin
						if (rd_cnt != (plen + 3) / 4) begin
							$display("Error at %0t ns: %0d payload reads, expected %0d",
								$time, rd_cnt, (plen + 3) / 4);
							errors++;
						end
						active = 0;
						frames_done++;
					end
					idx++;
				end
			end
			if (start_ok) begin
				build_header();
				pay.delete();
				rd_cnt = 0;
				idx = 0;
				active = 1;
			end
		end
	end

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int HALF_PERIOD = 10,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk   = 1'b0;
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

	always #(HALF_PERIOD) clk = ~clk;

endmodule

//--- dv/tb_props.sv
`timescale 1ns/1ps

module tb_props (
	input logic        clk,
	input logic        rst_n,
	input logic        sop,
	input logic        eop,
	input logic        data_out_rdy,
	input logic        data_out_rd,
	input logic        accept,
	input logic [31:0] data_out
);

	// A frame opens on its first word
	a_open: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(data_out_rdy) |-> sop)
		else $error("data_out_rdy rose without sop");

	a_sop_once: assert property (@(posedge clk) disable iff (!rst_n)
		(accept && sop) |=> !sop)
		else $error("sop stayed high after the first word was accepted");

	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(data_out_rdy && !data_out_rd) |=> $stable(data_out))
		else $error("data_out changed while the word was not accepted");

	// Ready drops right after the last word is taken
	a_close: assert property (@(posedge clk) disable iff (!rst_n)
		(accept && eop) |=> !data_out_rdy)
		else $error("data_out_rdy stayed high after the last word was accepted");

endmodule

//--- dv/tb_top.sv
`timescale 1ns/1ps

module tb_top;

	localparam int OPT_WORDS = 3;
	localparam int FRAMES = 40;
	localparam int CYCLE_LIMIT = FRAMES * 200;

	logic clk;
	logic rst_n;
	logic start;
	logic [47:0] mac_dst;
	logic [47:0] mac_src;
	logic [15:0] mac_type;
	logic [7:0] ip_dsf;
	logic [15:0] ip_id;
	logic [2:0] ip_flag;
	logic [12:0] ip_frag_offset;
	logic [7:0] ip_ttl;
	logic [7:0] ip_prot;
	logic [31:0] ip_src;
	logic [31:0] ip_dst;
	logic [15:0] tcp_src_port;
	logic [15:0] tcp_dst_port;
	logic [31:0] tcp_seq_num;
	logic [31:0] tcp_ack_num;
	logic [3:0] tcp_head_len;
	logic [5:0] tcp_flags;
	logic [15:0] tcp_window;
	logic [15:0] tcp_urgent_ptr;
	logic [OPT_WORDS*32-1:0] tcp_options;
	logic [15:0] payload_len;
	logic [15:0] payload_sum;
	logic data_out_rd;
	logic [31:0] data_in;
	logic [31:0] data_out;
	logic [1:0] be_out;
	logic data_out_rdy;
	logic sop;
	logic eop;
	logic data_in_rd;
	logic busy;
	int errors;
	int words_checked;
	int frames_done;
	int frames_started;
	int cycles;
	integer seed;
	logic busy_seen;
	logic ending_seen;

	tb_clock u_clock (.clk(clk), .rst_n(rst_n));

	tcp_frame_top #(.TCP_OPT_WORDS(OPT_WORDS)) uut (.*);

	tb_checker #(.OPT_WORDS(OPT_WORDS)) u_checker (.*);

	bind frame_sequencer tb_props u_props (
		.clk(clk),
		.rst_n(rst_n),
		.sop(sop),
		.eop(eop),
		.data_out_rdy(data_out_rdy),
		.data_out_rd(data_out_rd),
		.accept(accept),
		.data_out(data_out)
	);

	task automatic drive_random_fields();
		mac_dst        <= {16'($random(seed)), 32'($random(seed))};
		mac_src        <= {16'($random(seed)), 32'($random(seed))};
		mac_type       <= 16'($random(seed));
		ip_dsf         <= 8'($random(seed));
		ip_id          <= 16'($random(seed));
		ip_flag        <= 3'($random(seed));
		ip_frag_offset <= 13'($random(seed));
		ip_ttl         <= 8'($random(seed));
		ip_prot        <= 8'($random(seed));
		ip_src         <= 32'($random(seed));
		ip_dst         <= 32'($random(seed));
		tcp_src_port   <= 16'($random(seed));
		tcp_dst_port   <= 16'($random(seed));
		tcp_seq_num    <= 32'($random(seed));
		tcp_ack_num    <= 32'($random(seed));
		tcp_head_len   <= 4'(5 + {$random(seed)} % 4);
		tcp_flags      <= 6'($random(seed));
		tcp_window     <= 16'($random(seed));
		tcp_urgent_ptr <= 16'($random(seed));
		tcp_options    <= {32'($random(seed)), 32'($random(seed)), 32'($random(seed))};
		payload_len    <= 16'({$random(seed)} % 41);
		payload_sum    <= 16'($random(seed));
	endtask

	// Fall-through payload source
	always @(posedge clk) begin
		if (data_in_rd)
			data_in <= $random(seed);
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	// ------------------------------
	// Stimulus
	initial begin
		seed = 65;
		cycles = 0;
		frames_started = 0;
		start = 1'b0;
		data_out_rd = 1'b0;
		data_in = 32'h0;
		drive_random_fields();
		@(posedge rst_n);
		while (frames_done < FRAMES) begin
			@(negedge clk);
			busy_seen = busy;
			ending_seen = data_out_rdy && eop && data_out_rd;
			@(posedge clk);
			data_out_rd <= ({$random(seed)} % 10) < 7;
			if (start) begin
				start <= 1'b0;
			end else if (!busy_seen && frames_started < FRAMES) begin
				drive_random_fields();
				start <= 1'b1;
				frames_started++;
			end else if (busy_seen && !ending_seen && ({$random(seed)} % 8) == 0) begin
				// Start while busy, must be ignored
				drive_random_fields();
				start <= 1'b1;
			end
		end
		repeat (4) @(posedge clk);
		$display("Frames %0d, words checked %0d, errors %0d", frames_done, words_checked, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- framer/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer #(
	parameter int TCP_OPT_WORDS = 3
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     start,
	input  logic                     data_out_rd,
	input  logic [3:0]               tcp_head_len_q,
	input  logic [15:0]              payload_len_q,
	input  logic [31:0]              head_word,
	input  logic [31:0]              payload_word,
	output logic                     capture,
	output tcp_frame_pkg::word_idx_t word_idx,
	output logic                     accept,
	output logic                     in_payload,
	output logic [31:0]              data_out,
	output logic [1:0]               be_out,
	output logic                     data_out_rdy,
	output logic                     sop,
	output logic                     eop,
	output logic                     busy
);

	tcp_frame_pkg::frame_state_t state;
	logic [3:0] opt_words;
	logic [16:0] total_bytes;
	tcp_frame_pkg::word_idx_t last_idx;
	tcp_frame_pkg::word_idx_t boundary_idx;
	logic at_boundary;

	// Option count, limited to what the header block can serve
	always_comb begin
		if (tcp_head_len_q <= 4'(tcp_frame_pkg::TCP_BASE_WORDS))
			opt_words = '0;
		else if (tcp_head_len_q >= 4'(tcp_frame_pkg::TCP_BASE_WORDS + TCP_OPT_WORDS))
			opt_words = 4'(TCP_OPT_WORDS);
		else
			opt_words = tcp_head_len_q - 4'(tcp_frame_pkg::TCP_BASE_WORDS);
	end

	// ------------------------------
	// Frame geometry
	assign total_bytes = 17'(tcp_frame_pkg::ETH_HEAD_BYTES + tcp_frame_pkg::IP_HEAD_BYTES
		+ 4 * tcp_frame_pkg::TCP_BASE_WORDS) + {11'b0, opt_words, 2'b00} + {1'b0, payload_len_q};
	assign last_idx     = tcp_frame_pkg::word_idx_t'((total_bytes - 17'd1) >> 2);
	assign boundary_idx = tcp_frame_pkg::word_idx_t'(tcp_frame_pkg::BASE_HEAD_WORDS)
		+ {12'b0, opt_words};

	assign capture      = start & (state == tcp_frame_pkg::ST_IDLE);
	assign data_out_rdy = (state != tcp_frame_pkg::ST_IDLE);
	assign busy         = data_out_rdy;
	assign accept       = data_out_rdy & data_out_rd;
	assign at_boundary  = (state == tcp_frame_pkg::ST_HEADER) & (word_idx == boundary_idx);
	assign in_payload   = at_boundary | (state == tcp_frame_pkg::ST_PAYLOAD);

	assign sop    = data_out_rdy & (word_idx == '0);
	assign eop    = data_out_rdy & (word_idx == last_idx);
	assign be_out = eop ? total_bytes[1:0] : 2'b00;

	// Boundary word takes its low half from the first payload bytes
	always_comb begin
		if (state == tcp_frame_pkg::ST_PAYLOAD)
			data_out = payload_word;
		else if (at_boundary)
			data_out = {head_word[31:16], payload_word[15:0]};
		else
			data_out = head_word;
	end

	// ------------------------------
	// FSM and word pointer
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= tcp_frame_pkg::ST_IDLE;
			word_idx <= '0;
		end else if (capture) begin
			state    <= tcp_frame_pkg::ST_HEADER;
			word_idx <= '0;
		end else if (accept) begin
			if (eop) begin
				state    <= tcp_frame_pkg::ST_IDLE;
				word_idx <= '0;
			end else begin
				word_idx <= word_idx + 16'd1;
				if (at_boundary)
					state <= tcp_frame_pkg::ST_PAYLOAD;
			end
		end
	end

endmodule

//--- framer/payload_aligner.sv
`timescale 1ns/1ps

module payload_aligner (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              capture,
	input  logic                              accept,
	input  logic                              in_payload,
	input  logic [15:0]                       payload_len_q,
	input  logic [tcp_frame_pkg::WORD_W-1:0]  data_in,
	output logic [tcp_frame_pkg::WORD_W-1:0]  payload_word,
	output logic                              data_in_rd
);

	logic [tcp_frame_pkg::HALF_W-1:0] carry;
	logic [15:0] rd_count;
	logic [15:0] words_needed;
	logic more;

	// Source words covering the payload, rounded up
	assign words_needed = 16'(({1'b0, payload_len_q} + 17'd3) >> 2);
	assign more         = rd_count < words_needed;
	assign data_in_rd   = accept & in_payload & more;

	// Held low half of the last word, then the next word's upper half
	assign payload_word = {carry, more ? data_in[31:16] : 16'h0};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rd_count <= '0;
		else if (capture)
			rd_count <= '0;
		else if (data_in_rd)
			rd_count <= rd_count + 16'd1;
	end

	always_ff @(posedge clk) begin
		if (data_in_rd)
			carry <= data_in[15:0];
	end

endmodule

//--- header/header_checksum.sv
`timescale 1ns/1ps

module header_checksum #(
	parameter int TCP_OPT_WORDS = 3
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [7:0]                  ip_dsf_q,
	input  logic [15:0]                 ip_id_q,
	input  logic [2:0]                  ip_flag_q,
	input  logic [12:0]                 ip_frag_offset_q,
	input  logic [7:0]                  ip_ttl_q,
	input  logic [7:0]                  ip_prot_q,
	input  logic [31:0]                 ip_src_q,
	input  logic [31:0]                 ip_dst_q,
	input  logic [15:0]                 ip_total_len,
	input  logic [15:0]                 tcp_src_port_q,
	input  logic [15:0]                 tcp_dst_port_q,
	input  logic [31:0]                 tcp_seq_num_q,
	input  logic [31:0]                 tcp_ack_num_q,
	input  logic [3:0]                  tcp_head_len_q,
	input  logic [5:0]                  tcp_flags_q,
	input  logic [15:0]                 tcp_window_q,
	input  logic [15:0]                 tcp_urgent_ptr_q,
	input  logic [TCP_OPT_WORDS*32-1:0] tcp_options_q,
	input  logic [15:0]                 payload_len_q,
	input  logic [15:0]                 payload_sum,
	output logic [15:0]                 ip_chksum,
	output logic [15:0]                 tcp_chksum
);

	logic [31:0] ip_sum;
	logic [31:0] ip_fold1;
	logic [31:0] ip_fold2;
	logic [31:0] tcp_sum;
	logic [31:0] tcp_fold1;
	logic [31:0] tcp_fold2;
	logic [15:0] tcp_len;

	assign tcp_len = {10'b0, tcp_head_len_q, 2'b00} + payload_len_q;

	// Checksum field itself counts as zero in both sums
	always_comb begin
		ip_sum = {4'(tcp_frame_pkg::IP_VERSION), 4'(tcp_frame_pkg::IP_HEAD_WORDS), ip_dsf_q}
			+ ip_total_len + ip_id_q + {ip_flag_q, ip_frag_offset_q} + {ip_ttl_q, ip_prot_q}
			+ ip_src_q[31:16] + ip_src_q[15:0] + ip_dst_q[31:16] + ip_dst_q[15:0];

		// Pseudo-header first
		tcp_sum = ip_src_q[31:16] + ip_src_q[15:0] + ip_dst_q[31:16] + ip_dst_q[15:0]
			+ {8'h0, ip_prot_q} + tcp_len;
		tcp_sum = tcp_sum + tcp_src_port_q + tcp_dst_port_q
			+ tcp_seq_num_q[31:16] + tcp_seq_num_q[15:0]
			+ tcp_ack_num_q[31:16] + tcp_ack_num_q[15:0]
			+ {tcp_head_len_q, 6'b0, tcp_flags_q} + tcp_window_q + tcp_urgent_ptr_q
			+ payload_sum;
		for (int i = 0; i < 2 * TCP_OPT_WORDS; i++)
			tcp_sum = tcp_sum + tcp_options_q[i*16 +: 16];

		// Two end-around folds cover any carry out of the first
		ip_fold1  = ip_sum[31:16] + ip_sum[15:0];
		ip_fold2  = ip_fold1[31:16] + ip_fold1[15:0];
		tcp_fold1 = tcp_sum[31:16] + tcp_sum[15:0];
		tcp_fold2 = tcp_fold1[31:16] + tcp_fold1[15:0];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ip_chksum  <= '0;
			tcp_chksum <= '0;
		end else begin
			ip_chksum  <= ~ip_fold2[15:0];
			tcp_chksum <= ~tcp_fold2[15:0];
		end
	end

endmodule

//--- header/header_fields.sv
`timescale 1ns/1ps

module header_fields #(
	parameter int TCP_OPT_WORDS = 3
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        capture,
	input  logic [47:0]                 mac_dst,
	input  logic [47:0]                 mac_src,
	input  logic [15:0]                 mac_type,
	input  logic [7:0]                  ip_dsf,
	input  logic [15:0]                 ip_id,
	input  logic [2:0]                  ip_flag,
	input  logic [12:0]                 ip_frag_offset,
	input  logic [7:0]                  ip_ttl,
	input  logic [7:0]                  ip_prot,
	input  logic [31:0]                 ip_src,
	input  logic [31:0]                 ip_dst,
	input  logic [15:0]                 tcp_src_port,
	input  logic [15:0]                 tcp_dst_port,
	input  logic [31:0]                 tcp_seq_num,
	input  logic [31:0]                 tcp_ack_num,
	input  logic [3:0]                  tcp_head_len,
	input  logic [5:0]                  tcp_flags,
	input  logic [15:0]                 tcp_window,
	input  logic [15:0]                 tcp_urgent_ptr,
	input  logic [TCP_OPT_WORDS*32-1:0] tcp_options,
	input  logic [15:0]                 payload_len,
	input  logic [15:0]                 payload_sum,
	input  tcp_frame_pkg::word_idx_t    word_idx,
	input  logic [15:0]                 ip_chksum,
	input  logic [15:0]                 tcp_chksum,
	output logic [7:0]                  ip_dsf_q,
	output logic [15:0]                 ip_id_q,
	output logic [2:0]                  ip_flag_q,
	output logic [12:0]                 ip_frag_offset_q,
	output logic [7:0]                  ip_ttl_q,
	output logic [7:0]                  ip_prot_q,
	output logic [31:0]                 ip_src_q,
	output logic [31:0]                 ip_dst_q,
	output logic [15:0]                 ip_total_len,
	output logic [15:0]                 tcp_src_port_q,
	output logic [15:0]                 tcp_dst_port_q,
	output logic [31:0]                 tcp_seq_num_q,
	output logic [31:0]                 tcp_ack_num_q,
	output logic [3:0]                  tcp_head_len_q,
	output logic [5:0]                  tcp_flags_q,
	output logic [15:0]                 tcp_window_q,
	output logic [15:0]                 tcp_urgent_ptr_q,
	output logic [TCP_OPT_WORDS*32-1:0] tcp_options_q,
	output logic [15:0]                 payload_len_q,
	output logic [15:0]                 payload_sum_q,
	output logic [31:0]                 head_word
);

	logic [tcp_frame_pkg::MAC_ADDR_W-1:0] mac_dst_q;
	logic [tcp_frame_pkg::MAC_ADDR_W-1:0] mac_src_q;
	logic [15:0] mac_type_q;
	logic [TCP_OPT_WORDS*32-1:0] opt_masked;
	// Urgent pointer, options, then room for the first payload half
	logic [(TCP_OPT_WORDS+1)*32-1:0] tail_bits;
	tcp_frame_pkg::word_idx_t tail_idx;

	// Option words beyond the header length are sent as zero
	always_comb begin
		opt_masked = tcp_options;
		for (int j = 0; j < TCP_OPT_WORDS; j++) begin
			if (tcp_head_len <= 4'(tcp_frame_pkg::TCP_BASE_WORDS + j))
				opt_masked[(TCP_OPT_WORDS-1-j)*32 +: 32] = '0;
		end
	end

	// ------------------------------
	// Capture
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tcp_head_len_q <= '0;
			payload_len_q  <= '0;
		end else if (capture) begin
			tcp_head_len_q <= tcp_head_len;
			payload_len_q  <= payload_len;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			mac_dst_q        <= mac_dst;
			mac_src_q        <= mac_src;
			mac_type_q       <= mac_type;
			ip_dsf_q         <= ip_dsf;
			ip_id_q          <= ip_id;
			ip_flag_q        <= ip_flag;
			ip_frag_offset_q <= ip_frag_offset;
			ip_ttl_q         <= ip_ttl;
			ip_prot_q        <= ip_prot;
			ip_src_q         <= ip_src;
			ip_dst_q         <= ip_dst;
			tcp_src_port_q   <= tcp_src_port;
			tcp_dst_port_q   <= tcp_dst_port;
			tcp_seq_num_q    <= tcp_seq_num;
			tcp_ack_num_q    <= tcp_ack_num;
			tcp_flags_q      <= tcp_flags;
			tcp_window_q     <= tcp_window;
			tcp_urgent_ptr_q <= tcp_urgent_ptr;
			tcp_options_q    <= opt_masked;
			payload_sum_q    <= payload_sum;
		end
	end

	assign ip_total_len = 16'(tcp_frame_pkg::IP_HEAD_BYTES) + {10'b0, tcp_head_len_q, 2'b00}
		+ payload_len_q;

	// ------------------------------
	// Header word select
	assign tail_bits = {tcp_urgent_ptr_q, tcp_options_q, 16'h0};
	assign tail_idx  = word_idx - tcp_frame_pkg::word_idx_t'(tcp_frame_pkg::BASE_HEAD_WORDS);

	always_comb begin
		case (word_idx)
			16'd0:   head_word = mac_dst_q[47:16];
			16'd1:   head_word = {mac_dst_q[15:0], mac_src_q[47:32]};
			16'd2:   head_word = mac_src_q[31:0];
			16'd3:   head_word = {mac_type_q, 4'(tcp_frame_pkg::IP_VERSION),
				4'(tcp_frame_pkg::IP_HEAD_WORDS), ip_dsf_q};
			16'd4:   head_word = {ip_total_len, ip_id_q};
			16'd5:   head_word = {ip_flag_q, ip_frag_offset_q, ip_ttl_q, ip_prot_q};
			16'd6:   head_word = {ip_chksum, ip_src_q[31:16]};
			16'd7:   head_word = {ip_src_q[15:0], ip_dst_q[31:16]};
			16'd8:   head_word = {ip_dst_q[15:0], tcp_src_port_q};
			16'd9:   head_word = {tcp_dst_port_q, tcp_seq_num_q[31:16]};
			16'd10:  head_word = {tcp_seq_num_q[15:0], tcp_ack_num_q[31:16]};
			16'd11:  head_word = {tcp_ack_num_q[15:0], tcp_head_len_q, 6'b0, tcp_flags_q};
			16'd12:  head_word = {tcp_window_q, tcp_chksum};
			default: begin
				head_word = '0;
				for (int i = 0; i <= TCP_OPT_WORDS; i++) begin
					if (tail_idx == tcp_frame_pkg::word_idx_t'(i))
						head_word = tail_bits[(TCP_OPT_WORDS-i)*32 +: 32];
				end
			end
		endcase
	end

endmodule

//--- source/tcp_frame_top.sv
`timescale 1ns/1ps

module tcp_frame_top #(
	parameter int TCP_OPT_WORDS = 3
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          start,
	input  logic [47:0]                   mac_dst,
	input  logic [47:0]                   mac_src,
	input  logic [15:0]                   mac_type,
	input  logic [7:0]                    ip_dsf,
	input  logic [15:0]                   ip_id,
	input  logic [2:0]                    ip_flag,
	input  logic [12:0]                   ip_frag_offset,
	input  logic [7:0]                    ip_ttl,
	input  logic [7:0]                    ip_prot,
	input  logic [31:0]                   ip_src,
	input  logic [31:0]                   ip_dst,
	input  logic [15:0]                   tcp_src_port,
	input  logic [15:0]                   tcp_dst_port,
	input  logic [31:0]                   tcp_seq_num,
	input  logic [31:0]                   tcp_ack_num,
	input  logic [3:0]                    tcp_head_len,
	input  logic [5:0]                    tcp_flags,
	input  logic [15:0]                   tcp_window,
	input  logic [15:0]                   tcp_urgent_ptr,
	input  logic [TCP_OPT_WORDS*32-1:0]   tcp_options,
	input  logic [15:0]                   payload_len,
	input  logic [15:0]                   payload_sum,
	input  logic                          data_out_rd,
	input  logic [31:0]                   data_in,
	output logic [31:0]                   data_out,
	output logic [1:0]                    be_out,
	output logic                          data_out_rdy,
	output logic                          sop,
	output logic                          eop,
	output logic                          data_in_rd,
	output logic                          busy
);

	logic capture;
	logic accept;
	logic in_payload;
	tcp_frame_pkg::word_idx_t word_idx;
	logic [31:0] head_word;
	logic [31:0] payload_word;
	logic [15:0] ip_chksum;
	logic [15:0] tcp_chksum;

	// Captured fields
	logic [7:0]  ip_dsf_q;
	logic [15:0] ip_id_q;
	logic [2:0]  ip_flag_q;
	logic [12:0] ip_frag_offset_q;
	logic [7:0]  ip_ttl_q;
	logic [7:0]  ip_prot_q;
	logic [31:0] ip_src_q;
	logic [31:0] ip_dst_q;
	logic [15:0] ip_total_len;
	logic [15:0] tcp_src_port_q;
	logic [15:0] tcp_dst_port_q;
	logic [31:0] tcp_seq_num_q;
	logic [31:0] tcp_ack_num_q;
	logic [3:0]  tcp_head_len_q;
	logic [5:0]  tcp_flags_q;
	logic [15:0] tcp_window_q;
	logic [15:0] tcp_urgent_ptr_q;
	logic [TCP_OPT_WORDS*32-1:0] tcp_options_q;
	logic [15:0] payload_len_q;
	logic [15:0] payload_sum_q;

	header_fields #(.TCP_OPT_WORDS(TCP_OPT_WORDS)) u_fields (
		.clk(clk),
		.rst_n(rst_n),
		.capture(capture),
		.mac_dst(mac_dst),
		.mac_src(mac_src),
		.mac_type(mac_type),
		.ip_dsf(ip_dsf),
		.ip_id(ip_id),
		.ip_flag(ip_flag),
		.ip_frag_offset(ip_frag_offset),
		.ip_ttl(ip_ttl),
		.ip_prot(ip_prot),
		.ip_src(ip_src),
		.ip_dst(ip_dst),
		.tcp_src_port(tcp_src_port),
		.tcp_dst_port(tcp_dst_port),
		.tcp_seq_num(tcp_seq_num),
		.tcp_ack_num(tcp_ack_num),
		.tcp_head_len(tcp_head_len),
		.tcp_flags(tcp_flags),
		.tcp_window(tcp_window),
		.tcp_urgent_ptr(tcp_urgent_ptr),
		.tcp_options(tcp_options),
		.payload_len(payload_len),
		.payload_sum(payload_sum),
		.word_idx(word_idx),
		.ip_chksum(ip_chksum),
		.tcp_chksum(tcp_chksum),
		.ip_dsf_q(ip_dsf_q),
		.ip_id_q(ip_id_q),
		.ip_flag_q(ip_flag_q),
		.ip_frag_offset_q(ip_frag_offset_q),
		.ip_ttl_q(ip_ttl_q),
		.ip_prot_q(ip_prot_q),
		.ip_src_q(ip_src_q),
		.ip_dst_q(ip_dst_q),
		.ip_total_len(ip_total_len),
		.tcp_src_port_q(tcp_src_port_q),
		.tcp_dst_port_q(tcp_dst_port_q),
		.tcp_seq_num_q(tcp_seq_num_q),
		.tcp_ack_num_q(tcp_ack_num_q),
		.tcp_head_len_q(tcp_head_len_q),
		.tcp_flags_q(tcp_flags_q),
		.tcp_window_q(tcp_window_q),
		.tcp_urgent_ptr_q(tcp_urgent_ptr_q),
		.tcp_options_q(tcp_options_q),
		.payload_len_q(payload_len_q),
		.payload_sum_q(payload_sum_q),
		.head_word(head_word)
	);

	header_checksum #(.TCP_OPT_WORDS(TCP_OPT_WORDS)) u_checksum (
		.clk(clk),
		.rst_n(rst_n),
		.ip_dsf_q(ip_dsf_q),
		.ip_id_q(ip_id_q),
		.ip_flag_q(ip_flag_q),
		.ip_frag_offset_q(ip_frag_offset_q),
		.ip_ttl_q(ip_ttl_q),
		.ip_prot_q(ip_prot_q),
		.ip_src_q(ip_src_q),
		.ip_dst_q(ip_dst_q),
		.ip_total_len(ip_total_len),
		.tcp_src_port_q(tcp_src_port_q),
		.tcp_dst_port_q(tcp_dst_port_q),
		.tcp_seq_num_q(tcp_seq_num_q),
		.tcp_ack_num_q(tcp_ack_num_q),
		.tcp_head_len_q(tcp_head_len_q),
		.tcp_flags_q(tcp_flags_q),
		.tcp_window_q(tcp_window_q),
		.tcp_urgent_ptr_q(tcp_urgent_ptr_q),
		.tcp_options_q(tcp_options_q),
		.payload_len_q(payload_len_q),
		.payload_sum(payload_sum_q),
		.ip_chksum(ip_chksum),
		.tcp_chksum(tcp_chksum)
	);

	frame_sequencer #(.TCP_OPT_WORDS(TCP_OPT_WORDS)) u_sequencer (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.data_out_rd(data_out_rd),
		.tcp_head_len_q(tcp_head_len_q),
		.payload_len_q(payload_len_q),
		.head_word(head_word),
		.payload_word(payload_word),
		.capture(capture),
		.word_idx(word_idx),
		.accept(accept),
		.in_payload(in_payload),
		.data_out(data_out),
		.be_out(be_out),
		.data_out_rdy(data_out_rdy),
		.sop(sop),
		.eop(eop),
		.busy(busy)
	);

	payload_aligner u_aligner (
		.clk(clk),
		.rst_n(rst_n),
		.capture(capture),
		.accept(accept),
		.in_payload(in_payload),
		.payload_len_q(payload_len_q),
		.data_in(data_in),
		.payload_word(payload_word),
		.data_in_rd(data_in_rd)
	);

endmodule
